//--- design/lane_reduce_config.svh
`ifndef LANE_REDUCE_CONFIG_SVH
`define LANE_REDUCE_CONFIG_SVH

// number of voting lanes into the reducer
`define RED_NUM_LANES 16

// width of the saturating true-verdict counter
`define RED_CNT_WIDTH 16

// register levels in the AND tree, ceil(log2(lanes))
`define RED_TREE_LEVELS ($clog2(`RED_NUM_LANES))

`endif

//--- design/lane_pkg.sv
`include "lane_reduce_config.svh"

package lane_pkg;

    // one bit per lane
    // bit 0 is lane 0
    typedef logic [`RED_NUM_LANES-1:0] lane_vec_t;

    // lane bundle as it enters the AND tree
    // valid marks lanes that took part in this item
    // flag holds the per-lane vote already inverted for OR/NOR
    typedef struct packed {
        lane_vec_t valid;
        lane_vec_t flag;
    } lane_bundle_t;

    // a bundle with no lane valid
    // used as the disabled / reset value
    localparam lane_bundle_t LANE_BUNDLE_IDLE = '{valid: '0, flag: '0};

endpackage

//--- design/reduce_op_pkg.sv
package reduce_op_pkg;

    // reduction selected for one item
    // OR and NOR are built from the AND tree by De Morgan
    typedef enum logic [1:0] {
        OP_AND  = 2'b00,
        OP_OR   = 2'b01,
        OP_NAND = 2'b10,
        OP_NOR  = 2'b11
    } reduce_op_e;

    // opcode item travelling beside the tree
    typedef struct packed {
        logic       valid;
        reduce_op_e op;
    } op_tag_t;

    // flags go into the tree inverted for OR and NOR
    function automatic logic needs_in_inv(reduce_op_e op);
        return (op == OP_OR) || (op == OP_NOR);
    endfunction

    // tree root comes out inverted for OR and NAND
    function automatic logic needs_out_inv(reduce_op_e op);
        return (op == OP_OR) || (op == OP_NAND);
    endfunction

endpackage

//--- design/lane_capture.sv
`timescale 1ns/1ps
`include "lane_reduce_config.svh"

module lane_capture (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           i_en,
    input  logic [`RED_NUM_LANES-1:0]      i_valid,
    input  logic [`RED_NUM_LANES-1:0]      i_data,
    input  reduce_op_pkg::reduce_op_e      i_op,
    output lane_pkg::lane_bundle_t         o_lanes,
    output reduce_op_pkg::op_tag_t         o_tag
);

    // input side De Morgan select
    logic                        in_inv;
    // next values for the capture registers
    lane_pkg::lane_bundle_t      lanes_nxt;
    reduce_op_pkg::op_tag_t      tag_nxt;

    assign in_inv = reduce_op_pkg::needs_in_inv(i_op);

    // build next bundle and tag
    always_comb
    begin
        lanes_nxt = lane_pkg::LANE_BUNDLE_IDLE;
        tag_nxt   = '0;
        if (i_en)
        begin
            lanes_nxt.valid = i_valid;
            // OR/NOR run as AND of inverted flags
            lanes_nxt.flag  = i_data ^ {`RED_NUM_LANES{in_inv}};
            // any lane valid means an attempted item
            // full-valid check happens in the tree
            tag_nxt.valid   = |i_valid;
            tag_nxt.op      = i_op;
        end
    end

    // capture register, 1 cycle
    // disabled cycles load the idle value
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_lanes <= lane_pkg::LANE_BUNDLE_IDLE;
            o_tag   <= '0;
        end
        else
        begin
            o_lanes <= lanes_nxt;
            o_tag   <= tag_nxt;
        end
    end

endmodule

//--- design/and_tree_seq.sv
`timescale 1ns/1ps

module and_tree_seq #(
    parameter int NUM_INPUT_DATA = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_en,
    input  logic [NUM_INPUT_DATA-1:0]  i_valid,
    input  logic [NUM_INPUT_DATA-1:0]  i_data_bus,
    output logic                       o_valid,
    output logic                       o_data_bus
);

    // ceiling of log2 so non power of two counts get one extra level
    // e.g. 18 inputs -> 5 levels
    localparam int NUM_LEVEL = $clog2(NUM_INPUT_DATA);

    // level 0 is the gated input
    // levels 1..NUM_LEVEL are registered
    // level k holds ceil(N / 2^k) nodes
    genvar lv;
    genvar nd;
    generate
        for (lv = 0; lv <= NUM_LEVEL; lv = lv + 1)
        begin : g_lvl
            localparam int CNT = (NUM_INPUT_DATA + (1 << lv) - 1) >> lv;

            // node valid and node data of this level
            logic [CNT-1:0] vld;
            logic [CNT-1:0] dat;

            if (lv == 0)
            begin : g_in
                // enable gates the leaves
                assign vld = i_en ? i_valid : '0;
                assign dat = i_en ? i_data_bus : '0;
            end
            else
            begin : g_node
                // node count of the level below
                localparam int PREV_CNT = (NUM_INPUT_DATA + (1 << (lv - 1)) - 1) >> (lv - 1);

                // next state per node
                logic [CNT-1:0] vld_nxt;
                logic [CNT-1:0] dat_nxt;

                for (nd = 0; nd < CNT; nd = nd + 1)
                begin : g_and
                    if ((nd == CNT - 1) && (PREV_CNT % 2 == 1))
                    begin : g_pass
                        // odd last node passes its single child straight up
                        assign vld_nxt[nd] = i_en & g_lvl[lv-1].vld[2*nd];
                        assign dat_nxt[nd] = vld_nxt[nd] & g_lvl[lv-1].dat[2*nd];
                    end
                    else
                    begin : g_pair
                        // both children valid or the node stays empty
                        assign vld_nxt[nd] = i_en
                                           & g_lvl[lv-1].vld[2*nd]
                                           & g_lvl[lv-1].vld[2*nd+1];
                        // invalid node carries zero data
                        assign dat_nxt[nd] = vld_nxt[nd]
                                           & g_lvl[lv-1].dat[2*nd]
                                           & g_lvl[lv-1].dat[2*nd+1];
                    end
                end

                // one register stage per level
                always_ff @(posedge clk or negedge rst_n)
                begin
                    if (!rst_n)
                    begin
                        vld <= '0;
                        dat <= '0;
                    end
                    else
                    begin
                        vld <= vld_nxt;
                        dat <= dat_nxt;
                    end
                end
            end
        end
    endgenerate

    // root of the tree
    // single node at the top level
    assign o_valid    = g_lvl[NUM_LEVEL].vld[0];
    assign o_data_bus = g_lvl[NUM_LEVEL].dat[0];

endmodule

//--- design/vote_result_stage.sv
`timescale 1ns/1ps
`include "lane_reduce_config.svh"

module vote_result_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_en,
    input  reduce_op_pkg::op_tag_t        i_tag,
    input  logic                          i_root_valid,
    input  logic                          i_root_data,
    output logic                          o_valid,
    output logic                          o_result,
    output logic [`RED_CNT_WIDTH-1:0]     o_true_count
);

    // tag lined up with the tree root
    reduce_op_pkg::op_tag_t   tag_aln;
    // root item accepted this cycle
    logic                     fire;
    // root after output inversion
    logic                     verdict;
    // counter already at all ones
    logic                     cnt_max;

    generate
        if (`RED_TREE_LEVELS == 0)
        begin : g_no_dly
            // single lane means no tree registers
            assign tag_aln = i_tag;
        end
        else
        begin : g_dly
            // opcode delay line with one slot per tree level
            reduce_op_pkg::op_tag_t tag_sr [`RED_TREE_LEVELS];

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    for (int k = 0; k < `RED_TREE_LEVELS; k++)
                    begin
                        tag_sr[k] <= '0;
                    end
                end
                else if (!i_en)
                begin
                    // flushed with the tree on disable
                    for (int k = 0; k < `RED_TREE_LEVELS; k++)
                    begin
                        tag_sr[k] <= '0;
                    end
                end
                else
                begin
                    tag_sr[0] <= i_tag;
                    for (int k = 1; k < `RED_TREE_LEVELS; k++)
                    begin
                        tag_sr[k] <= tag_sr[k-1];
                    end
                end
            end

            assign tag_aln = tag_sr[`RED_TREE_LEVELS-1];
        end
    endgenerate

    // enable low kills the item sitting at the root too
    assign fire    = i_en & i_root_valid & tag_aln.valid;
    assign verdict = i_root_data ^ reduce_op_pkg::needs_out_inv(tag_aln.op);
    assign cnt_max = &o_true_count;

    // verdict register, strobe and true count
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_valid      <= 1'b0;
            o_result     <= 1'b0;
            o_true_count <= '0;
        end
        else
        begin
            o_valid <= fire;
            if (fire)
            begin
                o_result <= verdict;
                // saturates instead of wrapping
                if (verdict && !cnt_max)
                begin
                    o_true_count <= o_true_count + 1'b1;
                end
            end
        end
    end

endmodule

//--- design/lane_reduce_top.sv
`timescale 1ns/1ps
`include "lane_reduce_config.svh"

module lane_reduce_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_en,
    input  logic [`RED_NUM_LANES-1:0]     i_valid,
    input  logic [`RED_NUM_LANES-1:0]     i_data,
    input  reduce_op_pkg::reduce_op_e     i_op,
    output logic                          o_valid,
    output logic                          o_result,
    output logic [`RED_CNT_WIDTH-1:0]     o_true_count
);

    // capture stage to tree
    lane_pkg::lane_bundle_t   lanes;
    // capture stage to result stage
    reduce_op_pkg::op_tag_t   tag;
    // tree root
    logic                     root_valid;
    logic                     root_data;

    // stage 1, register lanes and opcode, input inversion
    lane_capture lane_capture_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_en     (i_en),
        .i_valid  (i_valid),
        .i_data   (i_data),
        .i_op     (i_op),
        .o_lanes  (lanes),
        .o_tag    (tag)
    );

    // stage 2, pipelined AND reduction
    and_tree_seq #(
        .NUM_INPUT_DATA (`RED_NUM_LANES)
    ) and_tree_seq_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_en       (i_en),
        .i_valid    (lanes.valid),
        .i_data_bus (lanes.flag),
        .o_valid    (root_valid),
        .o_data_bus (root_data)
    );

    // stage 3, output inversion, verdict and count
    vote_result_stage vote_result_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_en         (i_en),
        .i_tag        (tag),
        .i_root_valid (root_valid),
        .i_root_data  (root_data),
        .o_valid      (o_valid),
        .o_result     (o_result),
        .o_true_count (o_true_count)
    );

endmodule

//--- tb/lane_reduce_asserts.sv
`timescale 1ns/1ps
`include "lane_reduce_config.svh"

module lane_reduce_asserts (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_en,
    input  logic [`RED_NUM_LANES-1:0]     i_valid,
    input  logic [`RED_NUM_LANES-1:0]     i_data,
    input  reduce_op_pkg::reduce_op_e     i_op,
    input  logic                          o_valid,
    input  logic                          o_result,
    input  logic [`RED_CNT_WIDTH-1:0]     o_true_count
);

    // input sample to o_valid, capture + tree + result register
    localparam int DEPTH = `RED_TREE_LEVELS + 2;
    localparam logic [`RED_CNT_WIDTH-1:0] CNT_ONE = {{(`RED_CNT_WIDTH-1){1'b0}}, 1'b1};

    // expected item alive per pipeline slot, and its verdict
    logic [DEPTH-1:0]           exp_vld;
    logic [DEPTH-1:0]           exp_res;
    // expected true count, same update edge as the DUT
    logic [`RED_CNT_WIDTH-1:0]  exp_cnt;
    // set once the first verdict has come out
    logic                       seen_verdict;

    // per-check failure counters, summed for the testbench
    int err_valid = 0;
    int err_result = 0;
    int err_count = 0;
    int err_idle = 0;
    int fail_count;

    assign fail_count = err_valid + err_result + err_count + err_idle;

    // verdict straight from the opcode definition
    function automatic logic expected_vote(reduce_op_pkg::reduce_op_e op,
                                           logic [`RED_NUM_LANES-1:0] flags);
        case (op)
            reduce_op_pkg::OP_AND:  return &flags;
            reduce_op_pkg::OP_OR:   return |flags;
            reduce_op_pkg::OP_NAND: return ~&flags;
            default:                return ~|flags;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            exp_vld      <= '0;
            exp_res      <= '0;
            exp_cnt      <= '0;
            seen_verdict <= 1'b0;
        end
        else
        begin
            // item enters only full-valid; every later cycle needs enable too
            exp_vld <= {exp_vld[DEPTH-2:0] & {(DEPTH-1){i_en}}, i_en & (&i_valid)};
            exp_res <= {exp_res[DEPTH-2:0], expected_vote(i_op, i_data)};
            // counts on the edge that raises o_valid
            if (exp_vld[DEPTH-2] && i_en && exp_res[DEPTH-2] && (exp_cnt != '1))
            begin
                exp_cnt <= exp_cnt + CNT_ONE;
            end
            if (o_valid)
            begin
                seen_verdict <= 1'b1;
            end
        end
    end

    // strobe exactly DEPTH cycles after a surviving full-valid item
    a_valid_timing: assert property (@(posedge clk) disable iff (!rst_n)
        o_valid == exp_vld[DEPTH-1])
    else
    begin
        err_valid = err_valid + 1;
        $error("[ERROR] %0t: o_valid %0b, expected %0b", $time,
               $sampled(o_valid), $sampled(exp_vld[DEPTH-1]));
    end

    a_verdict: assert property (@(posedge clk) disable iff (!rst_n)
        o_valid |-> (o_result == exp_res[DEPTH-1]))
    else
    begin
        err_result = err_result + 1;
        $error("[ERROR] %0t: o_result %0b, expected %0b", $time,
               $sampled(o_result), $sampled(exp_res[DEPTH-1]));
    end

    // saturating count, checked every cycle
    a_true_count: assert property (@(posedge clk) disable iff (!rst_n)
        o_true_count == exp_cnt)
    else
    begin
        err_count = err_count + 1;
        $error("[ERROR] %0t: o_true_count %0d, expected %0d", $time,
               $sampled(o_true_count), $sampled(exp_cnt));
    end

    // result stays at its reset value until the first verdict
    a_idle_result: assert property (@(posedge clk) disable iff (!rst_n)
        (!seen_verdict && !o_valid) |-> !o_result)
    else
    begin
        err_idle = err_idle + 1;
        $error("[ERROR] %0t: o_result high before any verdict", $time);
    end

endmodule

bind lane_reduce_top lane_reduce_asserts lane_reduce_asserts_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_en         (i_en),
    .i_valid      (i_valid),
    .i_data       (i_data),
    .i_op         (i_op),
    .o_valid      (o_valid),
    .o_result     (o_result),
    .o_true_count (o_true_count)
);

//--- tb/tb_lane_reduce_top.sv
`timescale 1ns/1ps
`include "lane_reduce_config.svh"

module tb_lane_reduce_top;

    localparam int CLK_PERIOD   = 8;
    localparam int N            = `RED_NUM_LANES;
    localparam int DEPTH        = `RED_TREE_LEVELS + 2;
    localparam int RESET_CYCLES = 3;
    // isolated items for 4 ops x 4 flag patterns with a drain after each
    localparam int DIR_CYCLES   = 16 * (DEPTH + 2);
    localparam int RAND_ITEMS   = 300;
    // 12 items then one disabled cycle then 12 more
    localparam int EN_ROUNDS    = 4;
    localparam int EN_CYCLES    = EN_ROUNDS * 25;
    // enough true verdicts to hit the counter ceiling
    localparam int SAT_ITEMS    = (1 << `RED_CNT_WIDTH) + 4;
    localparam int DRAIN_CYCLES = 12;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 5 + DIR_CYCLES + RAND_ITEMS
                                   + EN_CYCLES + SAT_ITEMS + DRAIN_CYCLES + 200;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       i_en;
    logic [N-1:0]               i_valid;
    logic [N-1:0]               i_data;
    reduce_op_pkg::reduce_op_e  i_op;
    logic                       o_valid;
    logic                       o_result;
    logic [`RED_CNT_WIDTH-1:0]  o_true_count;

    integer seed = 32'h2053_5d54;

    reduce_op_pkg::reduce_op_e ops [4] = '{reduce_op_pkg::OP_AND, reduce_op_pkg::OP_OR,
                                           reduce_op_pkg::OP_NAND, reduce_op_pkg::OP_NOR};

    lane_reduce_top lane_reduce_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_en         (i_en),
        .i_valid      (i_valid),
        .i_data       (i_data),
        .i_op         (i_op),
        .o_valid      (o_valid),
        .o_result     (o_result),
        .o_true_count (o_true_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_and_stop();
        $display("TEST FAILED");
        $fatal(1, "run stopped after a failure");
    endtask

    // one input cycle applied on the falling edge
    task automatic drive_item(input logic en, input logic [N-1:0] vld,
                              input logic [N-1:0] dat, input reduce_op_pkg::reduce_op_e op);
        @(negedge clk);
        i_en    = en;
        i_valid = vld;
        i_data  = dat;
        i_op    = op;
    endtask

    // enabled but no lane valid
    task automatic drive_idle(input int cycles);
        repeat (cycles) drive_item(1'b1, '0, '0, reduce_op_pkg::OP_AND);
    endtask

    function automatic logic [N-1:0] random_lanes();
        logic [N-1:0] v;
        logic [31:0]  r;
        for (int b = 0; b < N; b++)
        begin
            if (b % 32 == 0)
            begin
                r = $random(seed);
            end
            v[b] = r[0];
            r    = r >> 1;
        end
        return v;
    endfunction

    // stop at the first checker mismatch
    always @(negedge clk)
    begin
        if (lane_reduce_top_inst.lane_reduce_asserts_inst.fail_count != 0)
        begin
            $display("[ERROR] %0t: bound checker flagged a wrong output", $time);
            fail_and_stop();
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        fail_and_stop();
    end

    initial
    begin
        logic [31:0]  sel;
        logic [N-1:0] vld;
        logic [N-1:0] dat;
        i_en    = 1'b0;
        i_valid = '0;
        i_data  = '0;
        i_op    = reduce_op_pkg::OP_AND;
        rst_n   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        drive_idle(4);

        // isolated items with all ones and all zeros then two random patterns
        for (int o = 0; o < 4; o++)
        begin
            for (int p = 0; p < 4; p++)
            begin
                dat = (p == 0) ? '1 : (p == 1) ? '0 : random_lanes();
                drive_item(1'b1, '1, dat, ops[o]);
                drive_idle(DEPTH + 1);
            end
        end

        // back to back items with mixed ops and some partial valid vectors
        for (int k = 0; k < RAND_ITEMS; k++)
        begin
            sel = $random(seed);
            vld = '1;
            if (sel[2:0] == 3'd0)
            begin
                vld[sel[31:8] % N] = 1'b0;
            end
            else if (sel[2:0] == 3'd1)
            begin
                vld = random_lanes();
            end
            dat = (sel[5:4] == 2'd0) ? '1 : (sel[5:4] == 2'd1) ? '0 : random_lanes();
            drive_item(1'b1, vld, dat, reduce_op_pkg::reduce_op_e'(sel[7:6]));
        end

        // single disabled cycle flushes everything in flight
        for (int r = 0; r < EN_ROUNDS; r++)
        begin
            for (int k = 0; k < 25; k++)
            begin
                sel = $random(seed);
                drive_item(k != 12, '1, random_lanes(), reduce_op_pkg::reduce_op_e'(sel[1:0]));
            end
        end

        // only true verdicts until the counter pins
        repeat (SAT_ITEMS) drive_item(1'b1, '1, '1, reduce_op_pkg::OP_AND);
        drive_idle(DRAIN_CYCLES);

        if ((lane_reduce_top_inst.lane_reduce_asserts_inst.fail_count == 0)
            && (o_true_count == '1))
        begin
            $display("TEST OK");
            $finish;
        end
        else
        begin
            $display("[ERROR] %0t: true count %0d, expected saturation", $time, o_true_count);
            fail_and_stop();
        end
    end

endmodule

//--- list.f
+incdir+design
design/lane_pkg.sv
design/reduce_op_pkg.sv
design/lane_capture.sv
design/and_tree_seq.sv
design/vote_result_stage.sv
design/lane_reduce_top.sv
tb/lane_reduce_asserts.sv
tb/tb_lane_reduce_top.sv

//--- Makefile
# simulator, flags, top module and file list
SIM       := verilator
TOP       := tb_lane_reduce_top
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM_FLAGS := --binary --timing --assert -j 0
# let checker errors reach the testbench, which then ends the run with $fatal
RUN_FLAGS := +verilator+error+limit+100

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the binary is the pass or fail result
run: compile
	./$(BIN) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)
